//--- spi_bridge_cfg.svh
`ifndef SPI_BRIDGE_CFG_SVH
`define SPI_BRIDGE_CFG_SVH

// Register address carried in the low bits of the command byte
`define SPI_ADDR_W 7

// Register contents and SPI byte size
`define SPI_DATA_W 8

// sck counter width N, at least 2
// One sck period lasts 2^N system clocks
`define SPI_CLK_DIV 3

`endif

//--- spi_bridge_pkg.sv
`include "spi_bridge_cfg.svh"

package spi_bridge_pkg;

  // Register address and data byte
  typedef logic [`SPI_ADDR_W-1:0] addr_t;
  typedef logic [`SPI_DATA_W-1:0] data_t;

  // Host command, wdata ignored for reads
  typedef struct packed {
    logic  write;
    addr_t addr;
    data_t wdata;
  } reg_cmd_t;

  // Response echoes the command and carries the byte shifted in
  // during the data phase
  typedef struct packed {
    logic  write;
    addr_t addr;
    data_t rdata;
  } reg_rsp_t;

  // Transaction sequencer
  typedef enum logic [2:0] {
    SEQ_IDLE,
    SEQ_SELECT,
    SEQ_CMD_BYTE,
    SEQ_DATA_BYTE,
    SEQ_RELEASE
  } seq_state_t;

  // Byte engine
  typedef enum logic [1:0] {
    XFER_IDLE,
    XFER_WAIT_HALF,
    XFER_TRANSFER
  } xfer_state_t;

endpackage

//--- spi_master_mode3.sv
`timescale 1ns/100ps

`include "spi_bridge_cfg.svh"

// SPI byte engine, mode 3 (CPOL=1, CPHA=1)
// sck idles high, mosi moves after the falling edge, miso sampled
// in the last clock before the rising edge
module spi_master_mode3
  import spi_bridge_pkg::*;
#(
  parameter int CLK_DIV = `SPI_CLK_DIV
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  start,
  input  data_t tx_byte,
  input  logic  miso,
  output logic  sck,
  output logic  mosi,
  output logic  xfer_busy,
  output logic  xfer_done,
  output data_t rx_byte
);

  localparam int BIT_W = $clog2(`SPI_DATA_W);

  // Last count of the low half of sck
  localparam logic [CLK_DIV-1:0] HALF_LAST = {1'b0, {(CLK_DIV-1){1'b1}}};

  xfer_state_t        state_d, state_q;
  logic [CLK_DIV-1:0] div_d, div_q;
  logic [BIT_W-1:0]   ctr_d, ctr_q;
  logic               mosi_d, mosi_q;
  logic               done_d, done_q;
  data_t              shift_d, shift_q;
  data_t              rx_d, rx_q;

  // sck follows the counter MSB only while bits are moving
  assign sck       = ~((state_q == XFER_TRANSFER) & ~div_q[CLK_DIV-1]);
  assign mosi      = mosi_q;
  assign xfer_busy = (state_q != XFER_IDLE);
  assign xfer_done = done_q;
  assign rx_byte   = rx_q;

  always_comb begin
    state_d = state_q;
    div_d   = div_q;
    ctr_d   = ctr_q;
    mosi_d  = mosi_q;
    done_d  = 1'b0;
    shift_d = shift_q;
    rx_d    = rx_q;

    case (state_q)
      XFER_IDLE: begin
        div_d  = '0;
        ctr_d  = '0;
        mosi_d = 1'b0;
        if (start) begin
          shift_d = tx_byte;
          state_d = XFER_WAIT_HALF;
        end
      end

      // Half a period of idle-high sck before the first falling edge
      XFER_WAIT_HALF: begin
        div_d = div_q + 1'b1;
        if (div_q == HALF_LAST) begin
          div_d   = '0;
          state_d = XFER_TRANSFER;
        end
      end

      XFER_TRANSFER: begin
        div_d = div_q + 1'b1;
        if (div_q == '0) begin
          // sck just fell
          mosi_d = shift_q[`SPI_DATA_W-1];
        end else if (div_q == HALF_LAST) begin
          // sck rises next clock
          shift_d = {shift_q[`SPI_DATA_W-2:0], miso};
        end else if (div_q == '1) begin
          ctr_d = ctr_q + 1'b1;
          if (ctr_q == '1) begin
            rx_d    = shift_q;
            done_d  = 1'b1;
            state_d = XFER_IDLE;
          end
        end
      end

      default: state_d = XFER_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= XFER_IDLE;
      div_q   <= '0;
      ctr_q   <= '0;
      mosi_q  <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      div_q   <= div_d;
      ctr_q   <= ctr_d;
      mosi_q  <= mosi_d;
      done_q  <= done_d;
    end
  end

  // Shifter and captured byte
  always_ff @(posedge clk) begin
    shift_q <= shift_d;
    rx_q    <= rx_d;
  end

endmodule

//--- spi_reg_sequencer.sv
`timescale 1ns/100ps

// Turns one host register command into a two-byte SPI transaction
// Byte 1 is {write, addr}, byte 2 is wdata or zero for a read
// The byte received during byte 2 becomes the response data
module spi_reg_sequencer
  import spi_bridge_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     cmd_valid,
  input  reg_cmd_t cmd,
  output logic     busy,
  output logic     cs_n,
  output logic     start,
  output data_t    tx_byte,
  input  logic     xfer_done,
  input  data_t    rx_byte,
  output logic     rsp_valid,
  output reg_rsp_t rsp
);

  seq_state_t state_d, state_q;
  logic       start_d, start_q;
  data_t      tx_d, tx_q;
  reg_cmd_t   cmd_d, cmd_q;
  reg_rsp_t   rsp_d, rsp_q;

  // Strobes arriving while busy are simply not looked at
  assign busy = (state_q != SEQ_IDLE);

  // Chip select framing and response strobe come straight from the state
  assign cs_n      = (state_q == SEQ_IDLE) || (state_q == SEQ_RELEASE);
  assign rsp_valid = (state_q == SEQ_RELEASE);

  assign start   = start_q;
  assign tx_byte = tx_q;
  assign rsp     = rsp_q;

  always_comb begin
    state_d = state_q;
    start_d = 1'b0;
    tx_d    = tx_q;
    cmd_d   = cmd_q;
    rsp_d   = rsp_q;

    case (state_q)
      SEQ_IDLE: begin
        if (cmd_valid) begin
          cmd_d   = cmd;
          state_d = SEQ_SELECT;
        end
      end

      // cs_n is low here, kick off the command byte
      SEQ_SELECT: begin
        start_d = 1'b1;
        tx_d    = {cmd_q.write, cmd_q.addr};
        state_d = SEQ_CMD_BYTE;
      end

      SEQ_CMD_BYTE: begin
        if (xfer_done) begin
          start_d = 1'b1;
          tx_d    = cmd_q.write ? cmd_q.wdata : '0;
          state_d = SEQ_DATA_BYTE;
        end
      end

      // Slave shifts out the register contents during this byte
      SEQ_DATA_BYTE: begin
        if (xfer_done) begin
          rsp_d.write = cmd_q.write;
          rsp_d.addr  = cmd_q.addr;
          rsp_d.rdata = rx_byte;
          state_d     = SEQ_RELEASE;
        end
      end

      SEQ_RELEASE: begin
        state_d = SEQ_IDLE;
      end

      default: state_d = SEQ_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= SEQ_IDLE;
      start_q <= 1'b0;
      rsp_q   <= '0;
    end else begin
      state_q <= state_d;
      start_q <= start_d;
      rsp_q   <= rsp_d;
    end
  end

  // Latched command and outgoing byte
  always_ff @(posedge clk) begin
    cmd_q <= cmd_d;
    tx_q  <= tx_d;
  end

endmodule

//--- spi_reg_bridge.sv
`timescale 1ns/100ps

// Host register commands over a mode-3 SPI link to a single slave
module spi_reg_bridge
  import spi_bridge_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     cmd_valid,
  input  reg_cmd_t cmd,
  output logic     busy,
  output logic     rsp_valid,
  output reg_rsp_t rsp,
  output logic     sck,
  output logic     mosi,
  input  logic     miso,
  output logic     cs_n
);

  // Sequencer to byte engine
  logic  start;
  data_t tx_byte;
  logic  xfer_done;
  data_t rx_byte;

  spi_reg_sequencer u_sequencer (
    .clk       (clk),
    .rst       (rst),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .busy      (busy),
    .cs_n      (cs_n),
    .start     (start),
    .tx_byte   (tx_byte),
    .xfer_done (xfer_done),
    .rx_byte   (rx_byte),
    .rsp_valid (rsp_valid),
    .rsp       (rsp)
  );

  // Sequencer paces itself on xfer_done, so the engine busy level stays open
  spi_master_mode3 u_master (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .tx_byte   (tx_byte),
    .miso      (miso),
    .sck       (sck),
    .mosi      (mosi),
    .xfer_busy (),
    .xfer_done (xfer_done),
    .rx_byte   (rx_byte)
  );

endmodule

//--- tb_spi_slave_model.sv
`timescale 1ns/100ps

// Behavioral mode-3 SPI slave with 128 byte registers
// Byte 1 is {write, addr}, byte 2 carries write data in and the
// addressed register out
module tb_spi_slave_model
  import spi_bridge_pkg::*;
(
  input  logic sck,
  input  logic mosi,
  output logic miso,
  input  logic cs_n
);

  data_t      regs [0:127];
  data_t      cmd_log [0:255];
  logic [7:0] cmd_count;
  int         frame_count;

  data_t      in_shift;
  data_t      out_shift;
  data_t      cmd_byte;
  int         bit_cnt;

  initial begin
    for (logic [7:0] idx = 8'd0; idx < 8'd128; idx++) begin
      regs[idx[6:0]] = idx ^ 8'hA5;
    end
    miso        = 1'b1;
    cmd_count   = 8'd0;
    frame_count = 0;
    in_shift    = '0;
    out_shift   = '0;
    cmd_byte    = '0;
    bit_cnt     = 0;
  end

  // New frame
  always @(negedge cs_n) begin
    bit_cnt   = 0;
    out_shift = '0;
    frame_count++;
  end

  // Capture mosi, MSB first
  always @(posedge sck) begin
    if (!cs_n) begin
      in_shift = {in_shift[6:0], mosi};
      bit_cnt++;
      if (bit_cnt == 8) begin
        cmd_byte           = in_shift;
        cmd_log[cmd_count] = in_shift;
        cmd_count          = cmd_count + 8'd1;
        out_shift          = regs[in_shift[6:0]];
      end else if (bit_cnt == 16 && cmd_byte[7]) begin
        regs[cmd_byte[6:0]] = in_shift;
      end
    end
  end

  // Next output bit on the falling edge
  always @(negedge sck) begin
    if (!cs_n) begin
      miso      = out_shift[7];
      out_shift = {out_shift[6:0], 1'b0};
    end
  end

endmodule

//--- tb_spi_reg_bridge.sv
`timescale 1ns/100ps

module tb_spi_reg_bridge
  import spi_bridge_pkg::*;
();

  localparam int WAIT_LIMIT = 2000;

  logic     clk;
  logic     rst;
  logic     cmd_valid;
  reg_cmd_t cmd;
  logic     busy;
  logic     rsp_valid;
  reg_rsp_t rsp;
  logic     sck;
  logic     mosi;
  logic     miso;
  logic     cs_n;

  data_t       shadow [0:127];
  logic [15:0] lfsr_state;
  int          mismatch_errors;
  int          timeout_errors;
  int          rsp_count;

  spi_reg_bridge UUT (
    .clk       (clk),
    .rst       (rst),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .busy      (busy),
    .rsp_valid (rsp_valid),
    .rsp       (rsp),
    .sck       (sck),
    .mosi      (mosi),
    .miso      (miso),
    .cs_n      (cs_n)
  );

  tb_spi_slave_model slave (
    .sck  (sck),
    .mosi (mosi),
    .miso (miso),
    .cs_n (cs_n)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Responses counted half a cycle after they appear
  always @(negedge clk) begin
    if (rsp_valid) rsp_count++;
  end

  // Galois LFSR stepped once per bit taken
  function automatic logic [15:0] take_bits(input int count);
    logic [15:0] bits;
    logic        out_bit;
    bits = '0;
    for (int i = 0; i < count; i++) begin
      out_bit    = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (out_bit) lfsr_state = lfsr_state ^ 16'hB400;
      bits = {bits[14:0], out_bit};
    end
    return bits;
  endfunction

  task automatic report_mismatch(input string test, input logic [15:0] expected,
                                 input logic [15:0] actual);
    mismatch_errors++;
    $display("CHECK FAILED %s: expected 0x%0h, actual 0x%0h", test, expected, actual);
  endtask

  task automatic abort_on_timeout(input string what);
    timeout_errors++;
    $display("Timed out waiting for %s", what);
    $display("Errors: %0d mismatches, %0d timeouts", mismatch_errors, timeout_errors);
    $display("test failed");
    $finish;
  endtask

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while (busy !== 1'b0) begin
      if (cycles == WAIT_LIMIT) abort_on_timeout("busy to drop");
      @(posedge clk);
      #2;
      cycles++;
    end
  endtask

  task automatic wait_response(output reg_rsp_t got);
    int cycles;
    cycles = 0;
    while (rsp_valid !== 1'b1) begin
      if (cycles == WAIT_LIMIT) abort_on_timeout("rsp_valid");
      @(posedge clk);
      #2;
      cycles++;
    end
    got = rsp;
  endtask

  // One-cycle strobe taken by the DUT on the next rising edge
  task automatic send_command(input logic write, input addr_t addr, input data_t wdata);
    cmd_valid   = 1'b1;
    cmd.write   = write;
    cmd.addr    = addr;
    cmd.wdata   = wdata;
    @(posedge clk);
    #2;
    cmd_valid = 1'b0;
  endtask

  task automatic check_framing(input string test, input logic write, input addr_t addr,
                               input int frames_before, input int rsps_before);
    if (slave.cmd_log[slave.cmd_count - 8'd1] !== {write, addr})
      report_mismatch(test, 16'({write, addr}), 16'(slave.cmd_log[slave.cmd_count - 8'd1]));
    if (slave.frame_count - frames_before != 1)
      report_mismatch(test, 16'd1, 16'(slave.frame_count - frames_before));
    if (rsp_count - rsps_before != 1)
      report_mismatch(test, 16'd1, 16'(rsp_count - rsps_before));
    if (cs_n !== 1'b1) report_mismatch(test, 16'd1, 16'(cs_n));
    if (slave.regs[addr] !== shadow[addr])
      report_mismatch(test, 16'(shadow[addr]), 16'(slave.regs[addr]));
  endtask

  // Every response returns the register value from before the command
  task automatic exchange(input string test, input logic write, input addr_t addr,
                          input data_t wdata);
    reg_rsp_t got;
    data_t    expected;
    int       frames_before;
    int       rsps_before;
    wait_idle();
    frames_before = slave.frame_count;
    rsps_before   = rsp_count;
    expected      = shadow[addr];
    send_command(write, addr, wdata);
    wait_response(got);
    if (got.write !== write) report_mismatch(test, 16'(write), 16'(got.write));
    if (got.addr !== addr) report_mismatch(test, 16'(addr), 16'(got.addr));
    if (got.rdata !== expected) report_mismatch(test, 16'(expected), 16'(got.rdata));
    if (write) shadow[addr] = wdata;
    @(posedge clk);
    #2;
    check_framing(test, write, addr, frames_before, rsps_before);
  endtask

  task automatic reset_levels();
    if (rsp !== '0) report_mismatch("reset_levels", 16'd0, 16'(rsp));
    if (mosi !== 1'b0) report_mismatch("reset_levels", 16'd0, 16'(mosi));
    repeat (20) begin
      if (cs_n !== 1'b1) report_mismatch("reset_levels", 16'd1, 16'(cs_n));
      if (sck !== 1'b1) report_mismatch("reset_levels", 16'd1, 16'(sck));
      if (busy !== 1'b0) report_mismatch("reset_levels", 16'd0, 16'(busy));
      if (rsp_valid !== 1'b0) report_mismatch("reset_levels", 16'd0, 16'(rsp_valid));
      @(posedge clk);
      #2;
    end
  endtask

  task automatic write_then_read();
    exchange("write_then_read", 1'b1, 7'h15, 8'h3C);
    exchange("write_then_read", 1'b0, 7'h15, 8'h00);
    // rsp still holds the read response
    if (rsp.rdata !== 8'h3C) report_mismatch("write_then_read", 16'h3C,
                                             16'(rsp.rdata));
  endtask

  // Address and data corners for the command byte
  task automatic command_framing();
    exchange("command_framing", 1'b0, 7'h00, 8'h00);
    exchange("command_framing", 1'b1, 7'h7F, 8'hFF);
    exchange("command_framing", 1'b0, 7'h7F, 8'h00);
    exchange("command_framing", 1'b1, 7'h00, 8'h00);
    exchange("command_framing", 1'b0, 7'h55, 8'hAA);
  endtask

  task automatic random_sweep();
    logic [15:0] bits;
    logic        write;
    addr_t       addr;
    data_t       wdata;
    for (int n = 0; n < 40; n++) begin
      bits  = take_bits(1);
      write = bits[0];
      bits  = take_bits(7);
      addr  = bits[6:0];
      bits  = take_bits(8);
      wdata = bits[7:0];
      exchange("random_sweep", write, addr, wdata);
    end
  endtask

  task automatic busy_drop();
    reg_rsp_t got;
    data_t    expected;
    int       frames_before;
    int       rsps_before;
    wait_idle();
    frames_before = slave.frame_count;
    rsps_before   = rsp_count;
    expected      = shadow[7'h40];
    send_command(1'b1, 7'h40, 8'h11);
    if (busy !== 1'b1) report_mismatch("busy_drop", 16'd1, 16'(busy));
    repeat (3) begin
      @(posedge clk);
      #2;
    end
    // Second strobe lands in the middle of the transaction
    send_command(1'b1, 7'h41, 8'h99);
    wait_response(got);
    if (got.addr !== 7'h40) report_mismatch("busy_drop", 16'h40, 16'(got.addr));
    if (got.rdata !== expected) report_mismatch("busy_drop", 16'(expected), 16'(got.rdata));
    shadow[7'h40] = 8'h11;
    // Long enough for a whole transaction to show up if one had been taken
    repeat (200) begin
      @(posedge clk);
      #2;
    end
    check_framing("busy_drop", 1'b1, 7'h40, frames_before, rsps_before);
    if (slave.regs[7'h41] !== shadow[7'h41])
      report_mismatch("busy_drop", 16'(shadow[7'h41]), 16'(slave.regs[7'h41]));
  endtask

  initial begin
    rst             = 1'b1;
    cmd_valid       = 1'b0;
    cmd             = '0;
    lfsr_state      = 16'd10;
    mismatch_errors = 0;
    timeout_errors  = 0;
    rsp_count       = 0;
    for (logic [7:0] idx = 8'd0; idx < 8'd128; idx++) begin
      shadow[idx[6:0]] = idx ^ 8'hA5;
    end

    repeat (16) @(posedge clk);
    #2;
    rst = 1'b0;

    reset_levels();
    write_then_read();
    command_framing();
    random_sweep();
    busy_drop();

    $display("Errors: %0d mismatches, %0d timeouts", mismatch_errors, timeout_errors);
    if (mismatch_errors == 0 && timeout_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- files.f
+incdir+.
spi_bridge_pkg.sv
spi_master_mode3.sv
spi_reg_sequencer.sv
spi_reg_bridge.sv
tb_spi_slave_model.sv
tb_spi_reg_bridge.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/100ps -f files.f \
  --top-module tb_spi_reg_bridge -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "test passed" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
